//--- logic/acq_pkg.sv
package acq_pkg;

    ////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////

    localparam int SAMPLE_W = 12;            // one adc conversion
    localparam int ADDR_W   = 10;            // circular buffer address
    localparam int DEPTH    = 1 << ADDR_W;   // buffer words, 1024

    ////////////////////////////////////////////////////////////
    // plain vector types
    ////////////////////////////////////////////////////////////

    typedef logic [SAMPLE_W-1:0] adc_sample_t;
    typedef logic [ADDR_W-1:0]   cbuf_addr_t;
    typedef logic [ADDR_W:0]     rd_count_t;     // one extra bit so a full buffer fits

    ////////////////////////////////////////////////////////////
    // structs
    ////////////////////////////////////////////////////////////

    // one buffer word, 26 bits, second sample in the upper half
    typedef struct packed {
        adc_sample_t second_sample;
        logic        second_ovr;
        adc_sample_t first_sample;
        logic        first_ovr;
    } sample_pair_t;

    // one access to the single ram port
    typedef struct packed {
        logic         wr;      // 1 = write, 0 = read
        cbuf_addr_t   addr;
        sample_pair_t wdata;   // ignored on reads
    } mem_req_t;

    // host readout command
    typedef struct packed {
        cbuf_addr_t start;
        rd_count_t  count;     // number of words, 0 is a no-op
    } rd_cmd_t;

endpackage

//--- logic/sample_source.sv
module sample_source (
    input  logic                 adc_clk,
    input  logic                 rst_n,
    input  acq_pkg::sample_pair_t adc_pair,         // deserialized pair from the adc
    input  logic                 cbuf_wr_en,        // capture enable
    input  logic                 use_dummy,         // 1 = test counter instead of adc
    input  logic                 dummy_reset_mode,  // clear the counter on each trigger
    input  logic                 trig_pulse,        // single cycle trigger
    output acq_pkg::sample_pair_t src_pair,
    output logic                 src_valid
);

    ////////////////////////////////////////////////////////////
    // test counter
    ////////////////////////////////////////////////////////////

    acq_pkg::adc_sample_t dummy_cnt;   // value for the next pair
    acq_pkg::adc_sample_t dummy_cur;   // value used this cycle
    logic                 dummy_clr;
    logic                 dummy_inc;

    assign dummy_clr = trig_pulse & dummy_reset_mode;
    assign dummy_inc = use_dummy & cbuf_wr_en;

    // a trigger zeroes the count seen in this very cycle,
    // so a trigger on the first capture cycle yields word 0 = 0
    assign dummy_cur = dummy_clr ? '0 : dummy_cnt;

    always_ff @(posedge adc_clk) begin
        if (!rst_n) begin
            dummy_cnt <= '0;
        end else begin
            dummy_cnt <= dummy_cur + acq_pkg::adc_sample_t'(dummy_inc);   // wraps at 4096
        end
    end

    ////////////////////////////////////////////////////////////
    // pair register
    ////////////////////////////////////////////////////////////

    // payload, no reset needed
    always_ff @(posedge adc_clk) begin
        if (use_dummy) begin
            src_pair.first_sample  <= dummy_cur;    // plain count
            src_pair.first_ovr     <= 1'b0;
            src_pair.second_sample <= ~dummy_cur;   // inverted count
            src_pair.second_ovr    <= 1'b0;
        end else begin
            src_pair <= adc_pair;                   // straight from the adc
        end
    end

    // valid follows the capture enable by one cycle
    always_ff @(posedge adc_clk) begin
        if (!rst_n) begin
            src_valid <= 1'b0;
        end else begin
            src_valid <= cbuf_wr_en;
        end
    end

endmodule

//--- logic/cbuf_writer.sv
module cbuf_writer (
    input  logic                  adc_clk,
    input  logic                  rst_n,
    input  acq_pkg::sample_pair_t src_pair,
    input  logic                  src_valid,
    output acq_pkg::mem_req_t     wr_req,
    output logic                  wr_req_valid,
    output acq_pkg::cbuf_addr_t   wr_addr      // next free slot, host uses it to find newest
);

    ////////////////////////////////////////////////////////////
    // wrapping write address
    ////////////////////////////////////////////////////////////

    // sits at 0 while capture is idle, so the first pair of a
    // capture always lands at address 0
    always_ff @(posedge adc_clk) begin
        if (!rst_n) begin
            wr_addr <= '0;
        end else if (!src_valid) begin
            wr_addr <= '0;                  // idle, park at the start
        end else begin
            wr_addr <= wr_addr + 1'b1;      // natural wrap at DEPTH
        end
    end

    ////////////////////////////////////////////////////////////
    // write request
    ////////////////////////////////////////////////////////////

    // one write per valid pair, issued in the same cycle
    assign wr_req_valid = src_valid;

    always_comb begin
        wr_req.wr    = 1'b1;       // writer only ever writes
        wr_req.addr  = wr_addr;
        wr_req.wdata = src_pair;
    end

endmodule

//--- logic/readout_engine.sv
module readout_engine (
    input  logic                  adc_clk,
    input  logic                  rst_n,
    // host command
    input  acq_pkg::rd_cmd_t      cmd,
    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    // buffer side, through the arbiter
    output acq_pkg::mem_req_t     rd_req,
    output logic                  rd_req_valid,
    input  logic                  rd_grant,
    input  acq_pkg::sample_pair_t rd_data,
    input  logic                  rd_data_valid,
    // output stream
    output acq_pkg::sample_pair_t out_pair,
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic                  done        // one cycle after the last word
);

    typedef enum logic [2:0] {
        IDLE,
        REQUEST,     // read held until the arbiter grants
        WAIT_DATA,   // ram latency
        PRESENT,     // word on the stream
        FINISH       // done pulse
    } rd_state_t;

    rd_state_t            state;
    acq_pkg::cbuf_addr_t  rd_addr;     // address of the current word
    acq_pkg::rd_count_t   remaining;   // words left, current one included

    ////////////////////////////////////////////////////////////
    // fsm
    ////////////////////////////////////////////////////////////

    always_ff @(posedge adc_clk) begin
        if (!rst_n) begin
            state     <= IDLE;
            rd_addr   <= '0;
            remaining <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (cmd_valid) begin
                        rd_addr   <= cmd.start;
                        remaining <= cmd.count;
                        state     <= (cmd.count == '0) ? FINISH : REQUEST;
                    end
                end
                REQUEST: if (rd_grant) state <= WAIT_DATA;   // capture may stall us here
                WAIT_DATA: if (rd_data_valid) state <= PRESENT;
                PRESENT: begin
                    if (out_ready) begin
                        rd_addr   <= rd_addr + 1'b1;          // wraps modulo DEPTH
                        remaining <= remaining - 1'b1;
                        state     <= (remaining == acq_pkg::rd_count_t'(1)) ? FINISH : REQUEST;
                    end
                end
                FINISH:  state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // output word, loaded once per read and held through back-pressure
    always_ff @(posedge adc_clk) begin
        if (state == WAIT_DATA && rd_data_valid) begin
            out_pair <= rd_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////

    assign cmd_ready    = (state == IDLE);
    assign rd_req_valid = (state == REQUEST);
    assign out_valid    = (state == PRESENT);
    assign done         = (state == FINISH);

    always_comb begin
        rd_req.wr    = 1'b0;
        rd_req.addr  = rd_addr;
        rd_req.wdata = '0;       // unused on a read
    end

    // the arbiter tag must only return data we asked for
    a_data_in_wait: assert property (
        @(posedge adc_clk) disable iff (!rst_n)
        rd_data_valid |-> state == WAIT_DATA
    );

endmodule

//--- logic/cbuf_arbiter.sv
module cbuf_arbiter (
    input  logic                  adc_clk,
    input  logic                  rst_n,
    // writer, highest priority
    input  acq_pkg::mem_req_t     wr_req,
    input  logic                  wr_req_valid,
    // reader
    input  acq_pkg::mem_req_t     rd_req,
    input  logic                  rd_req_valid,
    output logic                  rd_grant,
    // ram port
    output acq_pkg::mem_req_t     ram_req,
    output logic                  ram_en,
    input  acq_pkg::sample_pair_t ram_rdata,
    // read return
    output acq_pkg::sample_pair_t rd_data,
    output logic                  rd_data_valid
);

    logic rd_tag;   // a granted read is in the ram this cycle

    ////////////////////////////////////////////////////////////
    // grant
    ////////////////////////////////////////////////////////////

    // adc data can't wait, reader only gets idle slots
    assign rd_grant = rd_req_valid & ~wr_req_valid;
    assign ram_en   = wr_req_valid | rd_req_valid;
    assign ram_req  = wr_req_valid ? wr_req : rd_req;

    ////////////////////////////////////////////////////////////
    // read return
    ////////////////////////////////////////////////////////////

    always_ff @(posedge adc_clk) begin
        if (!rst_n) begin
            rd_tag <= 1'b0;
        end else begin
            rd_tag <= rd_grant;   // ram answers one edge later
        end
    end

    assign rd_data       = ram_rdata;
    assign rd_data_valid = rd_tag;

    // a write always takes the port at once and never produces
    // a read return in the cycle after
    a_wr_wins: assert property (
        @(posedge adc_clk) disable iff (!rst_n)
        wr_req_valid |-> (ram_en && ram_req.wr && ram_req.addr == wr_req.addr)
                         ##1 !rd_data_valid
    );

endmodule

//--- logic/cbuf_ram.sv
module cbuf_ram (
    input  logic                  adc_clk,
    input  acq_pkg::mem_req_t     ram_req,
    input  logic                  ram_en,
    output acq_pkg::sample_pair_t ram_rdata
);

    acq_pkg::sample_pair_t mem [acq_pkg::DEPTH];   // circular buffer storage

    // single port, one access per cycle
    always_ff @(posedge adc_clk) begin
        if (ram_en) begin
            if (ram_req.wr) begin
                mem[ram_req.addr] <= ram_req.wdata;
            end
            ram_rdata <= mem[ram_req.addr];   // registered read, old data on a write
        end
    end

endmodule

//--- logic/adc_acq_top.sv
module adc_acq_top (
    input  logic                  adc_clk,
    input  logic                  rst_n,
    // adc side
    input  acq_pkg::sample_pair_t adc_pair,
    input  logic                  cbuf_wr_en,
    input  logic                  use_dummy,
    input  logic                  dummy_reset_mode,
    input  logic                  trig_pulse,
    // host side
    input  acq_pkg::rd_cmd_t      cmd,
    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    output acq_pkg::sample_pair_t out_pair,
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic                  done,
    output acq_pkg::cbuf_addr_t   wr_addr
);

    acq_pkg::sample_pair_t src_pair;
    logic                  src_valid;
    acq_pkg::mem_req_t     wr_req;
    logic                  wr_req_valid;
    acq_pkg::mem_req_t     rd_req;
    logic                  rd_req_valid;
    logic                  rd_grant;
    acq_pkg::sample_pair_t rd_data;
    logic                  rd_data_valid;
    acq_pkg::mem_req_t     ram_req;
    logic                  ram_en;
    acq_pkg::sample_pair_t ram_rdata;

    ////////////////////////////////////////////////////////////
    // capture path
    ////////////////////////////////////////////////////////////

    sample_source source_i (
        .adc_clk          (adc_clk),
        .rst_n            (rst_n),
        .adc_pair         (adc_pair),
        .cbuf_wr_en       (cbuf_wr_en),
        .use_dummy        (use_dummy),
        .dummy_reset_mode (dummy_reset_mode),
        .trig_pulse       (trig_pulse),
        .src_pair         (src_pair),
        .src_valid        (src_valid)
    );

    cbuf_writer writer_i (
        .adc_clk      (adc_clk),
        .rst_n        (rst_n),
        .src_pair     (src_pair),
        .src_valid    (src_valid),
        .wr_req       (wr_req),
        .wr_req_valid (wr_req_valid),
        .wr_addr      (wr_addr)
    );

    ////////////////////////////////////////////////////////////
    // readout path
    ////////////////////////////////////////////////////////////

    readout_engine reader_i (
        .adc_clk       (adc_clk),
        .rst_n         (rst_n),
        .cmd           (cmd),
        .cmd_valid     (cmd_valid),
        .cmd_ready     (cmd_ready),
        .rd_req        (rd_req),
        .rd_req_valid  (rd_req_valid),
        .rd_grant      (rd_grant),
        .rd_data       (rd_data),
        .rd_data_valid (rd_data_valid),
        .out_pair      (out_pair),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .done          (done)
    );

    ////////////////////////////////////////////////////////////
    // shared buffer
    ////////////////////////////////////////////////////////////

    cbuf_arbiter arb_i (
        .adc_clk       (adc_clk),
        .rst_n         (rst_n),
        .wr_req        (wr_req),
        .wr_req_valid  (wr_req_valid),
        .rd_req        (rd_req),
        .rd_req_valid  (rd_req_valid),
        .rd_grant      (rd_grant),
        .ram_req       (ram_req),
        .ram_en        (ram_en),
        .ram_rdata     (ram_rdata),
        .rd_data       (rd_data),
        .rd_data_valid (rd_data_valid)
    );

    cbuf_ram ram_i (
        .adc_clk   (adc_clk),
        .ram_req   (ram_req),
        .ram_en    (ram_en),
        .ram_rdata (ram_rdata)
    );

endmodule

//--- verif/adc_acq_tb.sv
module adc_acq_tb;

    localparam int CLK_PERIOD  = 20;
    localparam int RESET_CYCLES = 8;
    // captured plus read words over all tests
    localparam int TOTAL_WORDS = 200 * 2 + 300 * 3 + 1300 + 1024 + 8 + 256;
    localparam int MARGIN      = 2000;   // cycles of slack for setup and drain

    logic                  adc_clk = 1'b0;
    logic                  rst_n;
    acq_pkg::sample_pair_t adc_pair;
    logic                  cbuf_wr_en;
    logic                  use_dummy;
    logic                  dummy_reset_mode;
    logic                  trig_pulse;
    acq_pkg::rd_cmd_t      cmd;
    logic                  cmd_valid;
    logic                  cmd_ready;
    acq_pkg::sample_pair_t out_pair;
    logic                  out_valid;
    logic                  out_ready;
    logic                  done;
    acq_pkg::cbuf_addr_t   wr_addr;

    acq_pkg::sample_pair_t ref_mem [acq_pkg::DEPTH];   // buffer model
    acq_pkg::sample_pair_t adc_hist [2048];            // pairs driven in the last capture
    acq_pkg::sample_pair_t exp_q [$];                  // words still owed by the readout
    acq_pkg::sample_pair_t held_pair;
    logic                  was_stalled = 1'b0;
    logic                  bp_en = 1'b0;               // random out_ready when set
    int                    done_count = 0;
    int                    cmds_sent = 0;

    adc_acq_top dut_i (
        .adc_clk          (adc_clk),
        .rst_n            (rst_n),
        .adc_pair         (adc_pair),
        .cbuf_wr_en       (cbuf_wr_en),
        .use_dummy        (use_dummy),
        .dummy_reset_mode (dummy_reset_mode),
        .trig_pulse       (trig_pulse),
        .cmd              (cmd),
        .cmd_valid        (cmd_valid),
        .cmd_ready        (cmd_ready),
        .out_pair         (out_pair),
        .out_valid        (out_valid),
        .out_ready        (out_ready),
        .done             (done),
        .wr_addr          (wr_addr)
    );

    always #(CLK_PERIOD / 2) adc_clk = ~adc_clk;

    ////////////////////////////////////////////////////////////
    // reporting and compare helpers
    ////////////////////////////////////////////////////////////

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_pair(input string name, input acq_pkg::sample_pair_t got,
                              input acq_pkg::sample_pair_t exp);
        if (got !== exp)
            fail_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_addr(input string name, input acq_pkg::cbuf_addr_t got,
                              input acq_pkg::cbuf_addr_t exp);
        if (got !== exp)
            fail_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
    endtask

    function automatic acq_pkg::sample_pair_t random_pair();
        logic [25:0] bits;
        bits = 26'($urandom);
        return bits;
    endfunction

    // expected buffer word for capture index idx
    function automatic acq_pkg::sample_pair_t expected_pair(input int idx, input logic dummy);
        acq_pkg::sample_pair_t p;
        if (dummy) begin
            p.first_sample  = acq_pkg::adc_sample_t'(idx);    // counter, wraps at 4096
            p.first_ovr     = 1'b0;
            p.second_sample = ~acq_pkg::adc_sample_t'(idx);   // inverted counter
            p.second_ovr    = 1'b0;
        end else begin
            p = adc_hist[11'(idx)];                           // whatever was driven
        end
        return p;
    endfunction

    ////////////////////////////////////////////////////////////
    // stimulus tasks
    ////////////////////////////////////////////////////////////

    task automatic capture(input int n, input logic dummy);
        acq_pkg::sample_pair_t p;
        @(posedge adc_clk);
        use_dummy        <= dummy;
        dummy_reset_mode <= dummy;
        for (int i = 0; i < n; i++) begin
            @(posedge adc_clk);
            p = random_pair();
            adc_hist[11'(i)] = p;
            adc_pair   <= p;
            cbuf_wr_en <= 1'b1;
            trig_pulse <= (i == 0) & dummy;                   // trigger with the capture edge
            ref_mem[10'(i)] = expected_pair(i, dummy);        // later pairs overwrite on wrap
        end
        @(posedge adc_clk);
        cbuf_wr_en <= 1'b0;
        trig_pulse <= 1'b0;
        repeat (3) @(posedge adc_clk);                        // two-cycle write path drains
        check_addr("wr_addr", wr_addr, '0);                   // parked again when idle
    endtask

    task automatic read_back(input int start, input int count);
        acq_pkg::rd_cmd_t c;
        for (int k = 0; k < count; k++)
            exp_q.push_back(ref_mem[10'(start + k)]);         // walk wraps modulo DEPTH
        c.start = acq_pkg::cbuf_addr_t'(start);
        c.count = acq_pkg::rd_count_t'(count);
        @(posedge adc_clk);
        cmd       <= c;
        cmd_valid <= 1'b1;
        do @(posedge adc_clk); while (!cmd_ready);
        cmd_valid <= 1'b0;
        cmds_sent++;
        do @(posedge adc_clk); while (!done);
        @(posedge adc_clk);
        check_flag("done", done, 1'b0);                       // single pulse only
        if (done_count != cmds_sent)
            fail_run("done pulsed a different number of times than commands were sent");
        if (exp_q.size() != 0)
            fail_run("done came before every requested word was transferred");
    endtask

    ////////////////////////////////////////////////////////////
    // stream monitor and back-pressure
    ////////////////////////////////////////////////////////////

    always @(posedge adc_clk) begin
        if (was_stalled)
            check_pair("out_pair held", out_pair, held_pair); // stalled word must not move
        if (out_valid && out_ready) begin
            if (exp_q.size() == 0)
                fail_run("a word was transferred that no command asked for");
            else
                check_pair("out_pair", out_pair, exp_q.pop_front());
        end
        if (done)
            done_count++;
        was_stalled = out_valid && !out_ready;
        held_pair   = out_pair;
    end

    always @(posedge adc_clk) begin
        if (bp_en)
            out_ready <= 1'($urandom);   // coin flip per cycle
        else
            out_ready <= 1'b1;
    end

    // watchdog, about four cycles per word plus slack
    initial begin
        #((TOTAL_WORDS * 4 + MARGIN) * CLK_PERIOD);
        fail_run("the run timed out before all tests finished");
    end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(13));
        rst_n            = 1'b0;
        adc_pair         = '0;
        cbuf_wr_en       = 1'b0;
        use_dummy        = 1'b0;
        dummy_reset_mode = 1'b0;
        trig_pulse       = 1'b0;
        cmd              = '0;
        cmd_valid        = 1'b0;
        out_ready        = 1'b0;
        repeat (RESET_CYCLES) @(posedge adc_clk);
        rst_n <= 1'b1;
        @(posedge adc_clk);

        check_flag("out_valid", out_valid, 1'b0);             // idle state after reset
        check_flag("done", done, 1'b0);
        check_flag("cmd_ready", cmd_ready, 1'b1);
        check_flag("wr_req_valid", dut_i.wr_req_valid, 1'b0);
        check_addr("wr_addr", wr_addr, '0);

        capture(200, 1'b0);                                   // random adc pairs
        read_back(0, 200);

        capture(300, 1'b1);                                   // counter left at 300
        capture(300, 1'b1);                                   // trigger must clear it again
        read_back(0, 300);

        capture(1300, 1'b0);                                  // overruns the buffer
        read_back(0, 1024);
        read_back(1020, 8);                                   // readout wraps to 0..3

        bp_en <= 1'b1;
        read_back(100, 256);
        bp_en <= 1'b0;
        @(posedge adc_clk);

        if (exp_q.size() == 0 && done_count == cmds_sent) begin
            $display("all tests passed");
            $finish;
        end else begin
            fail_run("words were left unread at the end of the run");
        end
    end

endmodule

//--- adc_capture.f
logic/acq_pkg.sv
logic/sample_source.sv
logic/cbuf_writer.sv
logic/readout_engine.sv
logic/cbuf_arbiter.sv
logic/cbuf_ram.sv
logic/adc_acq_top.sv
verif/adc_acq_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= adc_acq_tb
FILELIST  ?= adc_capture.f
PASS_MSG  := all tests passed
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
